//--- design/eth_mux_settings.svh
// ethernet mux settings

`ifndef ETH_MUX_SETTINGS_SVH
`define ETH_MUX_SETTINGS_SVH

// number of frame sources
`define ETH_MUX_SOURCES 4

// payload stream widths
`define ETH_MUX_DATA_W 8
`define ETH_MUX_USER_W 1

// header field widths
`define ETH_MAC_W 48
`define ETH_TYPE_W 16

`endif

//--- design/eth_mux_pkg.sv
// ethernet mux types

`include "eth_mux_settings.svh"

package eth_mux_pkg;

  // frame header as seen on the header handshake, 112 bits
  typedef struct packed {
    logic [`ETH_MAC_W-1:0]  dest_mac;
    logic [`ETH_MAC_W-1:0]  src_mac;
    logic [`ETH_TYPE_W-1:0] eth_type;
  } eth_hdr_t;

  // index of one source
  typedef logic [$clog2(`ETH_MUX_SOURCES)-1:0] src_idx_t;

endpackage

//--- design/eth_payload_if.sv
// payload stream interface

`include "eth_mux_settings.svh"

interface eth_payload_if;

  logic [`ETH_MUX_DATA_W-1:0] data;
  logic [`ETH_MUX_USER_W-1:0] user;
  logic                       last;
  logic                       valid;
  logic                       ready;

  // source holds its beat while valid is high and ready is low
  modport source (
    output data, user, last, valid,
    input  ready
  );

  modport sink (
    input  data, user, last, valid,
    output ready
  );

endinterface

//--- design/eth_grant_if.sv
// frame arbitration interface

`include "eth_mux_settings.svh"

interface eth_grant_if;

  logic [`ETH_MUX_SOURCES-1:0] request;
  logic                        release_pulse;
  logic [`ETH_MUX_SOURCES-1:0] grant;
  logic                        grant_valid;
  eth_mux_pkg::src_idx_t       grant_index;

  modport arbiter (
    input  request, release_pulse,
    output grant, grant_valid, grant_index
  );

  // release is a single cycle pulse once the granted frame is complete
  modport requester (
    output request, release_pulse,
    input  grant, grant_valid, grant_index
  );

endinterface

//--- design/frame_arbiter.sv
// round-robin frame arbiter

`include "eth_mux_settings.svh"

module frame_arbiter (
  input logic          clk,
  input logic          rst,
  eth_grant_if.arbiter arb
);

  localparam int N = `ETH_MUX_SOURCES;

  logic [N-1:0]          grant_q;
  logic                  grant_valid_q;
  eth_mux_pkg::src_idx_t grant_index_q;
  eth_mux_pkg::src_idx_t pointer_q;
  eth_mux_pkg::src_idx_t pick;
  eth_mux_pkg::src_idx_t pick_next;
  logic                  found;
  int                    idx;

  assign arb.grant       = grant_q;
  assign arb.grant_valid = grant_valid_q;
  assign arb.grant_index = grant_index_q;

  // first requester at or after the pointer, wrapping around
  always_comb begin
    found = 1'b0;
    pick  = pointer_q;
    idx   = 0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(pointer_q) + i) % N;
      if (!found && arb.request[idx]) begin
        found = 1'b1;
        pick  = eth_mux_pkg::src_idx_t'(idx);
      end
    end
  end

  // pointer moves to the source after the winner
  assign pick_next = (int'(pick) == N - 1) ? '0 : pick + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_valid_q <= 1'b0;
      grant_q       <= '0;
      grant_index_q <= '0;
      pointer_q     <= '0;
    end else if (grant_valid_q) begin
      // grant is held until the switch reports the frame done
      if (arb.release_pulse) begin
        grant_valid_q <= 1'b0;
        grant_q       <= '0;
      end
    end else if (found) begin
      grant_valid_q <= 1'b1;
      grant_q       <= {{(N-1){1'b0}}, 1'b1} << pick;
      grant_index_q <= pick;
      pointer_q     <= pick_next;
    end
  end

endmodule

//--- design/payload_skid_buffer.sv
// payload skid buffer

`include "eth_mux_settings.svh"

module payload_skid_buffer (
  input  logic                       clk,
  input  logic                       rst,
  eth_payload_if.sink                in,
  output logic [`ETH_MUX_DATA_W-1:0] m_tdata,
  output logic [`ETH_MUX_USER_W-1:0] m_tuser,
  output logic                       m_tlast,
  output logic                       m_tvalid,
  input  logic                       m_tready
);

  logic [`ETH_MUX_DATA_W-1:0] out_data;
  logic [`ETH_MUX_USER_W-1:0] out_user;
  logic                       out_last;
  logic                       out_valid;
  logic [`ETH_MUX_DATA_W-1:0] tmp_data;
  logic [`ETH_MUX_USER_W-1:0] tmp_user;
  logic                       tmp_last;
  logic                       tmp_valid;
  logic                       ready_q;
  logic                       ready_early;
  logic                       out_valid_next;
  logic                       tmp_valid_next;
  logic                       in_to_out;
  logic                       in_to_tmp;
  logic                       tmp_to_out;

  assign m_tdata  = out_data;
  assign m_tuser  = out_user;
  assign m_tlast  = out_last;
  assign m_tvalid = out_valid;
  assign in.ready = ready_q;

  // room for one more beat next cycle
  assign ready_early = m_tready || (!tmp_valid && !out_valid);

  always_comb begin
    out_valid_next = out_valid;
    tmp_valid_next = tmp_valid;
    in_to_out      = 1'b0;
    in_to_tmp      = 1'b0;
    tmp_to_out     = 1'b0;
    if (in.valid) begin
      if (m_tready || !out_valid) begin
        out_valid_next = 1'b1;
        in_to_out      = 1'b1;
      end else begin
        // output stalled, park the beat
        tmp_valid_next = 1'b1;
        in_to_tmp      = 1'b1;
      end
    end else if (m_tready) begin
      out_valid_next = tmp_valid;
      tmp_valid_next = 1'b0;
      tmp_to_out     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      tmp_valid <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      out_valid <= out_valid_next;
      tmp_valid <= tmp_valid_next;
      ready_q   <= ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      out_data <= in.data;
      out_user <= in.user;
      out_last <= in.last;
    end else if (tmp_to_out) begin
      out_data <= tmp_data;
      out_user <= tmp_user;
      out_last <= tmp_last;
    end
    if (in_to_tmp) begin
      tmp_data <= in.data;
      tmp_user <= in.user;
      tmp_last <= in.last;
    end
  end

endmodule

//--- design/eth_frame_switch.sv
// frame switch for the granted source

`include "eth_mux_settings.svh"

module eth_frame_switch (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [`ETH_MUX_SOURCES-1:0]                      s_hdr_valid,
  output logic [`ETH_MUX_SOURCES-1:0]                      s_hdr_ready,
  input  eth_mux_pkg::eth_hdr_t [`ETH_MUX_SOURCES-1:0]     s_hdr,
  input  logic [`ETH_MUX_SOURCES-1:0][`ETH_MUX_DATA_W-1:0] s_tdata,
  input  logic [`ETH_MUX_SOURCES-1:0][`ETH_MUX_USER_W-1:0] s_tuser,
  input  logic [`ETH_MUX_SOURCES-1:0]                      s_tlast,
  input  logic [`ETH_MUX_SOURCES-1:0]                      s_tvalid,
  output logic [`ETH_MUX_SOURCES-1:0]                      s_tready,
  output logic                                             m_hdr_valid,
  input  logic                                             m_hdr_ready,
  output eth_mux_pkg::eth_hdr_t                            m_hdr,
  eth_grant_if.requester                                   arb,
  eth_payload_if.source                                    out
);

  localparam int N = `ETH_MUX_SOURCES;

  logic [N-1:0]          hdr_ready_q;
  logic                  hdr_valid_q;
  eth_mux_pkg::eth_hdr_t hdr_q;
  logic                  hdr_captured;
  logic                  hdr_taken;
  logic                  last_seen;
  logic                  release_q;
  logic                  grant_valid_q;
  logic                  capture;
  logic                  hdr_now;
  logic                  last_now;
  logic                  pay_ready;
  eth_mux_pkg::src_idx_t sel;

  assign sel = arb.grant_index;

  // a source asks only while it is not the one being served
  assign arb.request       = s_hdr_valid & ~arb.grant;
  assign arb.release_pulse = release_q;

  // one header per grant, and only when the output register can take it
  assign capture = arb.grant_valid && !hdr_captured && (!hdr_valid_q || m_hdr_ready);
  assign hdr_now = |(hdr_ready_q & s_hdr_valid);

  // payload opens a cycle after grant and closes after the last beat
  assign pay_ready = out.ready && arb.grant_valid && grant_valid_q && !last_seen;
  assign last_now  = out.valid && out.last;

  assign out.data  = s_tdata[sel];
  assign out.user  = s_tuser[sel];
  assign out.last  = s_tlast[sel];
  assign out.valid = s_tvalid[sel] && pay_ready;
  assign s_tready  = {N{pay_ready}} & arb.grant;

  assign s_hdr_ready = hdr_ready_q;
  assign m_hdr_valid = hdr_valid_q;
  assign m_hdr       = hdr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_ready_q   <= '0;
      hdr_valid_q   <= 1'b0;
      hdr_captured  <= 1'b0;
      hdr_taken     <= 1'b0;
      last_seen     <= 1'b0;
      release_q     <= 1'b0;
      grant_valid_q <= 1'b0;
    end else begin
      grant_valid_q <= arb.grant_valid;
      hdr_ready_q   <= capture ? arb.grant : '0;

      if (capture) begin
        hdr_valid_q <= 1'b1;
      end else if (m_hdr_ready) begin
        hdr_valid_q <= 1'b0;
      end

      // done once header and last beat have both passed, in any order
      release_q <= (hdr_taken || hdr_now) && (last_seen || last_now) && !release_q;

      if (release_q) begin
        hdr_captured <= 1'b0;
        hdr_taken    <= 1'b0;
        last_seen    <= 1'b0;
      end else begin
        if (capture) begin
          hdr_captured <= 1'b1;
        end
        if (hdr_now) begin
          hdr_taken <= 1'b1;
        end
        if (last_now) begin
          last_seen <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      hdr_q <= s_hdr[sel];
    end
  end

endmodule

//--- design/eth_arb_mux.sv
// arbitrated ethernet frame mux

`include "eth_mux_settings.svh"

module eth_arb_mux (
  input  logic                                         clk,
  input  logic                                         rst,

  // per-source header and payload, packed across sources
  input  logic [`ETH_MUX_SOURCES-1:0]                  s_hdr_valid,
  output logic [`ETH_MUX_SOURCES-1:0]                  s_hdr_ready,
  input  logic [`ETH_MUX_SOURCES*`ETH_MAC_W-1:0]       s_dest_mac,
  input  logic [`ETH_MUX_SOURCES*`ETH_MAC_W-1:0]       s_src_mac,
  input  logic [`ETH_MUX_SOURCES*`ETH_TYPE_W-1:0]      s_eth_type,
  input  logic [`ETH_MUX_SOURCES*`ETH_MUX_DATA_W-1:0]  s_tdata,
  input  logic [`ETH_MUX_SOURCES*`ETH_MUX_USER_W-1:0]  s_tuser,
  input  logic [`ETH_MUX_SOURCES-1:0]                  s_tlast,
  input  logic [`ETH_MUX_SOURCES-1:0]                  s_tvalid,
  output logic [`ETH_MUX_SOURCES-1:0]                  s_tready,

  // merged output
  output logic                                         m_hdr_valid,
  input  logic                                         m_hdr_ready,
  output logic [`ETH_MAC_W-1:0]                        m_dest_mac,
  output logic [`ETH_MAC_W-1:0]                        m_src_mac,
  output logic [`ETH_TYPE_W-1:0]                       m_eth_type,
  output logic [`ETH_MUX_DATA_W-1:0]                   m_tdata,
  output logic [`ETH_MUX_USER_W-1:0]                   m_tuser,
  output logic                                         m_tlast,
  output logic                                         m_tvalid,
  input  logic                                         m_tready
);

  eth_mux_pkg::eth_hdr_t [`ETH_MUX_SOURCES-1:0] s_hdr;
  eth_mux_pkg::eth_hdr_t                        m_hdr;

  eth_payload_if pay_if ();
  eth_grant_if   grant_if ();

  // gather the flat header fields into one header per source
  for (genvar i = 0; i < `ETH_MUX_SOURCES; i++) begin : g_hdr
    assign s_hdr[i].dest_mac = s_dest_mac[i*`ETH_MAC_W +: `ETH_MAC_W];
    assign s_hdr[i].src_mac  = s_src_mac[i*`ETH_MAC_W +: `ETH_MAC_W];
    assign s_hdr[i].eth_type = s_eth_type[i*`ETH_TYPE_W +: `ETH_TYPE_W];
  end

  assign m_dest_mac = m_hdr.dest_mac;
  assign m_src_mac  = m_hdr.src_mac;
  assign m_eth_type = m_hdr.eth_type;

  frame_arbiter i_arbiter (
    .clk (clk),
    .rst (rst),
    .arb (grant_if.arbiter)
  );

  eth_frame_switch i_switch (
    .clk         (clk),
    .rst         (rst),
    .s_hdr_valid (s_hdr_valid),
    .s_hdr_ready (s_hdr_ready),
    .s_hdr       (s_hdr),
    .s_tdata     (s_tdata),
    .s_tuser     (s_tuser),
    .s_tlast     (s_tlast),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .m_hdr_valid (m_hdr_valid),
    .m_hdr_ready (m_hdr_ready),
    .m_hdr       (m_hdr),
    .arb         (grant_if.requester),
    .out         (pay_if.source)
  );

  payload_skid_buffer i_skid (
    .clk      (clk),
    .rst      (rst),
    .in       (pay_if.sink),
    .m_tdata  (m_tdata),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

endmodule

//--- tb/eth_arb_mux_tb.sv
// frame mux testbench

`include "eth_mux_settings.svh"

module eth_arb_mux_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `ETH_MUX_SOURCES;
  localparam int FRAMES = 12;
  localparam int TOTAL = N * FRAMES;
  localparam int MAX_BEATS = 6;
  localparam int BEAT_W = `ETH_MUX_DATA_W + `ETH_MUX_USER_W;
  localparam int LIMIT_NS = TOTAL * 40 * 40;
  localparam int IDLE = 0;
  localparam int GRANTED = 1;
  localparam int RELEASING = 2;

  logic                                      clk = 1'b0;
  logic                                      rst;
  logic [N-1:0]                              s_hdr_valid;
  logic [N-1:0]                              s_hdr_ready;
  logic [N*`ETH_MAC_W-1:0]                   s_dest_mac;
  logic [N*`ETH_MAC_W-1:0]                   s_src_mac;
  logic [N*`ETH_TYPE_W-1:0]                  s_eth_type;
  logic [N*`ETH_MUX_DATA_W-1:0]              s_tdata;
  logic [N*`ETH_MUX_USER_W-1:0]              s_tuser;
  logic [N-1:0]                              s_tlast;
  logic [N-1:0]                              s_tvalid;
  logic [N-1:0]                              s_tready;
  logic                                      m_hdr_valid;
  logic                                      m_hdr_ready;
  logic [`ETH_MAC_W-1:0]                     m_dest_mac;
  logic [`ETH_MAC_W-1:0]                     m_src_mac;
  logic [`ETH_TYPE_W-1:0]                    m_eth_type;
  logic [`ETH_MUX_DATA_W-1:0]                m_tdata;
  logic [`ETH_MUX_USER_W-1:0]                m_tuser;
  logic                                      m_tlast;
  logic                                      m_tvalid;
  logic                                      m_tready;

  // frames offered by each source
  eth_mux_pkg::eth_hdr_t hdr_tab[N][FRAMES];
  logic [BEAT_W-1:0]     beat_tab[N][FRAMES][MAX_BEATS];
  int                    len_tab[N][FRAMES];
  bit                    wait_tab[N][FRAMES];

  // source drivers
  logic [31:0]  lfsr;
  int           hidx[N];
  int           pidx[N];
  int           pbeat[N];
  logic [N-1:0] hdr_took;
  logic [N-1:0] beat_took;

  // reference model
  int order_q[$];
  int next_frame[N];
  int ptr;
  int state;
  int wait_cnt;
  int gnt_src;
  bit hdr_seen;
  bit last_seen;
  int hdr_pos;
  int pay_pos;
  int beat_pos;
  int beat_count;
  int errors;

  eth_arb_mux i_dut (.*);

  always #20 clk = ~clk;

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic build_frames();
    for (int s = 0; s < N; s++) begin
      for (int k = 0; k < FRAMES; k++) begin
        len_tab[s][k] = 1 + int'(take_bits(3) % 6);
        wait_tab[s][k] = take_bits(1) != 0;
        hdr_tab[s][k].dest_mac[47:16] = take_bits(32);
        hdr_tab[s][k].dest_mac[15:0] = 16'(take_bits(16));
        hdr_tab[s][k].src_mac[47:16] = take_bits(32);
        hdr_tab[s][k].src_mac[15:8] = 8'(take_bits(8));
        // low byte tags source and frame number
        hdr_tab[s][k].src_mac[7:0] = 8'(s * 16 + k);
        hdr_tab[s][k].eth_type = 16'(take_bits(16));
        for (int b = 0; b < MAX_BEATS; b++) begin
          beat_tab[s][k][b] = BEAT_W'(take_bits(BEAT_W));
        end
      end
    end
  endtask

  task automatic drive_inputs();
    logic [BEAT_W-1:0] beat;
    for (int s = 0; s < N; s++) begin
      if (s_hdr_valid[s] && !hdr_took[s]) begin
        s_hdr_valid[s] = 1'b1;
      end else if (hidx[s] < FRAMES && take_bits(1) != 0) begin
        s_hdr_valid[s] = 1'b1;
        s_dest_mac[s*`ETH_MAC_W +: `ETH_MAC_W] = hdr_tab[s][hidx[s]].dest_mac;
        s_src_mac[s*`ETH_MAC_W +: `ETH_MAC_W] = hdr_tab[s][hidx[s]].src_mac;
        s_eth_type[s*`ETH_TYPE_W +: `ETH_TYPE_W] = hdr_tab[s][hidx[s]].eth_type;
      end else begin
        s_hdr_valid[s] = 1'b0;
      end
      // a stalled beat is held, some frames wait for their header first
      if (s_tvalid[s] && !beat_took[s]) begin
        s_tvalid[s] = 1'b1;
      end else if (pidx[s] < FRAMES && !(wait_tab[s][pidx[s]] && hidx[s] <= pidx[s]) &&
                   take_bits(2) != 0) begin
        beat = beat_tab[s][pidx[s]][pbeat[s]];
        s_tvalid[s] = 1'b1;
        s_tdata[s*`ETH_MUX_DATA_W +: `ETH_MUX_DATA_W] = beat[`ETH_MUX_DATA_W-1:0];
        s_tuser[s*`ETH_MUX_USER_W +: `ETH_MUX_USER_W] = beat[BEAT_W-1:`ETH_MUX_DATA_W];
        s_tlast[s] = pbeat[s] == len_tab[s][pidx[s]] - 1;
      end else begin
        s_tvalid[s] = 1'b0;
      end
    end
    m_hdr_ready = take_bits(2) != 0;
    m_tready = take_bits(2) != 0;
  endtask

  task automatic arbitrate();
    bit found;
    int s;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      s = (ptr + i) % N;
      if (!found && s_hdr_valid[s]) begin
        found = 1'b1;
        gnt_src = s;
      end
    end
    ptr = (gnt_src + 1) % N;
    if (next_frame[gnt_src] >= FRAMES) begin
      report_fault($sformatf("source %0d was granted with no frame left", gnt_src));
    end
    order_q.push_back(gnt_src * FRAMES + next_frame[gnt_src]);
    next_frame[gnt_src]++;
    state = GRANTED;
    hdr_seen = 1'b0;
    last_seen = 1'b0;
  endtask

  task automatic check_outputs();
    int id;
    eth_mux_pkg::eth_hdr_t exp_hdr;
    logic [BEAT_W-1:0] exp_beat;
    bit exp_last;
    if (m_hdr_valid && m_hdr_ready) begin
      if (hdr_pos >= order_q.size()) begin
        report_fault("a header left the mux with no granted frame behind it");
      end else begin
        id = order_q[hdr_pos];
        exp_hdr = hdr_tab[id / FRAMES][id % FRAMES];
        if (m_dest_mac !== exp_hdr.dest_mac) report_value("m_dest_mac", m_dest_mac,
                                                           exp_hdr.dest_mac);
        if (m_src_mac !== exp_hdr.src_mac) report_value("m_src_mac", m_src_mac,
                                                         exp_hdr.src_mac);
        if (m_eth_type !== exp_hdr.eth_type) report_value("m_eth_type", m_eth_type,
                                                           exp_hdr.eth_type);
        hdr_pos++;
      end
    end
    if (m_tvalid && m_tready) begin
      if (pay_pos >= order_q.size()) begin
        report_fault("a payload beat left the mux with no granted frame behind it");
      end else begin
        id = order_q[pay_pos];
        exp_beat = beat_tab[id / FRAMES][id % FRAMES][beat_pos];
        exp_last = beat_pos == len_tab[id / FRAMES][id % FRAMES] - 1;
        if (m_tdata !== exp_beat[`ETH_MUX_DATA_W-1:0]) begin
          report_value("m_tdata", m_tdata, exp_beat[`ETH_MUX_DATA_W-1:0]);
        end
        if (m_tuser !== exp_beat[BEAT_W-1:`ETH_MUX_DATA_W]) begin
          report_value("m_tuser", m_tuser, exp_beat[BEAT_W-1:`ETH_MUX_DATA_W]);
        end
        if (m_tlast !== exp_last) report_value("m_tlast", m_tlast, exp_last);
        beat_count++;
        beat_pos = exp_last ? 0 : beat_pos + 1;
        pay_pos = exp_last ? pay_pos + 1 : pay_pos;
      end
    end
  endtask

  // sampled at the rising edge, before any input moves
  task automatic observe();
    for (int s = 0; s < N; s++) begin
      hdr_took[s] = s_hdr_valid[s] && s_hdr_ready[s];
      beat_took[s] = s_tvalid[s] && s_tready[s];
      if (hdr_took[s]) hidx[s]++;
      if (beat_took[s] && pbeat[s] == len_tab[s][pidx[s]] - 1) begin
        pbeat[s] = 0;
        pidx[s]++;
      end else if (beat_took[s]) begin
        pbeat[s]++;
      end
    end
    if (state == RELEASING) begin
      wait_cnt--;
      if (wait_cnt == 0) state = IDLE;
    end
    if (state == IDLE && s_hdr_valid != '0) arbitrate();
    for (int s = 0; s < N; s++) begin
      if ((s_hdr_ready[s] || s_tready[s]) && !(state == GRANTED && s == gnt_src)) begin
        report_fault($sformatf("ready reached source %0d while it held no grant", s));
      end
    end
    // release one cycle after header and last beat, arbitration one later
    if (state == GRANTED) begin
      if (hdr_took[gnt_src]) hdr_seen = 1'b1;
      if (beat_took[gnt_src] && s_tlast[gnt_src]) last_seen = 1'b1;
      if (hdr_seen && last_seen) begin
        state = RELEASING;
        wait_cnt = 2;
      end
    end
    check_outputs();
  endtask

  initial begin
    #(LIMIT_NS);
    $display("Error: timeout, not all frames came out of the mux in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    lfsr = 32'hba6c_8483;
    errors = 0;
    beat_count = 0;
    hdr_pos = 0;
    pay_pos = 0;
    beat_pos = 0;
    ptr = 0;
    state = IDLE;
    for (int s = 0; s < N; s++) begin
      hidx[s] = 0;
      pidx[s] = 0;
      pbeat[s] = 0;
      next_frame[s] = 0;
    end
    hdr_took = '0;
    beat_took = '0;
    rst = 1'b1;
    s_hdr_valid = '0;
    s_dest_mac = '0;
    s_src_mac = '0;
    s_eth_type = '0;
    s_tdata = '0;
    s_tuser = '0;
    s_tlast = '0;
    s_tvalid = '0;
    m_hdr_ready = 1'b0;
    m_tready = 1'b0;
    build_frames();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    if (m_hdr_valid !== 1'b0) report_value("m_hdr_valid", m_hdr_valid, 0);
    if (m_tvalid !== 1'b0) report_value("m_tvalid", m_tvalid, 0);
    if (s_hdr_ready !== '0) report_value("s_hdr_ready", s_hdr_ready, 0);
    if (s_tready !== '0) report_value("s_tready", s_tready, 0);
    #2;
    while (hdr_pos < TOTAL || pay_pos < TOTAL) begin
      drive_inputs();
      @(posedge clk);
      observe();
      #2;
    end
    // every source must have handed over all headers and payload
    for (int s = 0; s < N; s++) begin
      if (hidx[s] != FRAMES || pidx[s] != FRAMES) begin
        report_fault($sformatf("source %0d did not hand over all of its frames", s));
      end
    end
    $display("Headers checked: %0d, beats checked: %0d, errors: %0d",
             hdr_pos, beat_count, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- eth_arb_mux.f
+incdir+design
design/eth_mux_pkg.sv
design/eth_payload_if.sv
design/eth_grant_if.sv
design/frame_arbiter.sv
design/payload_skid_buffer.sv
design/eth_frame_switch.sv
design/eth_arb_mux.sv
tb/eth_arb_mux_tb.sv

//--- Bender.yml
package:
  name: eth_arb_mux

sources:
  - include_dirs:
      - design
    files:
      - design/eth_mux_pkg.sv
      - design/eth_payload_if.sv
      - design/eth_grant_if.sv
      - design/frame_arbiter.sv
      - design/payload_skid_buffer.sv
      - design/eth_frame_switch.sv
      - design/eth_arb_mux.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/eth_arb_mux_tb.sv
